//--- sim.f
isa_pkg.sv
pipe_pkg.sv
mips_controller.sv
mips_regfile.sv
mips_hazard.sv
mips_dmem.sv
mips_datapath.sv
mips_core.sv
mips_props.sv
tb_mips.sv

//--- Bender.yml
package:
  name: mips_pipe

sources:
  - files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - mips_controller.sv
      - mips_regfile.sv
      - mips_hazard.sv
      - mips_dmem.sv
      - mips_datapath.sv
      - mips_core.sv
  - target: test
    files:
      - mips_props.sv
      - tb_mips.sv

//--- tb_mips.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips;

	localparam int PROG_WORDS   = 64;
	localparam int RESET_CYCLES = 16;
	// Twenty instructions plus stalls and flushes, with margin
	localparam int TEST_CYCLES  = 400;
	localparam int NUM_TESTS    = 6;
	localparam int CYCLE_LIMIT  = NUM_TESTS * (RESET_CYCLES + TEST_CYCLES);

	logic clk;
	logic rst_n_i;
	pipe_pkg::pc_t imem_addr;
	isa_pkg::instr_u imem_instr;
	logic dmem_we;
	pipe_pkg::word_t dmem_addr;
	pipe_pkg::word_t dmem_wdata;

	logic [31:0] prog [PROG_WORDS];
	int prog_len;
	pipe_pkg::word_t exp_addr [$];
	pipe_pkg::word_t exp_data [$];
	logic collecting;
	integer seed;
	int cycles;
	int errors;
	int test_errors;
	int tests_passed;
	int tests_failed;

	mips_core uut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.imem_addr_o(imem_addr),
		.imem_instr_i(imem_instr),
		.dmem_we_o(dmem_we),
		.dmem_addr_o(dmem_addr),
		.dmem_wdata_o(dmem_wdata)
	);

	// Past the end of the program the core fetches nops
	assign imem_instr = (imem_addr < PROG_WORDS * 4) ? prog[imem_addr[7:2]] : '0;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Stores are sampled away from the active edge
	always @(negedge clk) begin
		if (collecting && dmem_we === 1'b1) begin
			check_store(dmem_addr, dmem_wdata);
		end
	end

	task automatic check_store(input pipe_pkg::word_t addr, input pipe_pkg::word_t data);
		pipe_pkg::word_t want_addr;
		pipe_pkg::word_t want_data;
		if (exp_addr.size() == 0) begin
			$display("Unexpected store of %h to address %h", data, addr);
			test_errors++;
		end else begin
			want_addr = exp_addr.pop_front();
			want_data = exp_data.pop_front();
			if (addr !== want_addr || data !== want_data) begin
				$display("[FAIL] %0t ns: store expected mem[%h] <= %h, got mem[%h] <= %h",
					$time, want_addr, want_data, addr, data);
				test_errors++;
			end
		end
	endtask

	function automatic logic [31:0] alu_rr(input logic [5:0] funct,
			input pipe_pkg::reg_addr_t rd, input pipe_pkg::reg_addr_t rs,
			input pipe_pkg::reg_addr_t rt);
		return {isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	// Operand order follows the assembly form op rt, rs, imm
	function automatic logic [31:0] imm_form(input logic [5:0] opcode,
			input pipe_pkg::reg_addr_t rt, input pipe_pkg::reg_addr_t rs,
			input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_to(input int word_idx);
		return {isa_pkg::OP_J, 26'(word_idx)};
	endfunction

	// Two's complement value of a 16-bit field
	function automatic pipe_pkg::word_t sign_extend(input logic [15:0] imm);
		int value;
		value = int'(imm);
		if (imm[15]) begin
			value = value - 65536;
		end
		return pipe_pkg::word_t'(value);
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic expect_store(input pipe_pkg::word_t addr, input pipe_pkg::word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic enter_reset();
		@(posedge clk);
		rst_n_i <= 1'b0;
		@(posedge clk);
		// Core sits in reset while the next program is written
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = '0;
		end
		prog_len = 0;
		exp_addr.delete();
		exp_data.delete();
		test_errors = 0;
	endtask

	task automatic run_program(input string name);
		repeat (RESET_CYCLES - 1) begin
			@(posedge clk);
		end
		rst_n_i <= 1'b1;
		collecting = 1'b1;
		// Done once the last expected store has been seen
		while (exp_addr.size() != 0) begin
			@(posedge clk);
		end
		collecting = 1'b0;
		errors += test_errors;
		if (test_errors == 0) begin
			tests_passed++;
			$display("%0t ns  %s: passed", $time, name);
		end else begin
			tests_failed++;
			$display("%0t ns  %s: failed with %0d errors", $time, name, test_errors);
		end
	endtask

	task automatic test_rtype_forwarding();
		pipe_pkg::word_t a;
		pipe_pkg::word_t b;
		pipe_pkg::word_t sum;
		pipe_pkg::word_t dif;
		pipe_pkg::word_t conj;
		pipe_pkg::word_t disj;
		enter_reset();
		a    = 32'd240;
		b    = 32'd60;
		sum  = a + b;
		dif  = sum - b;
		conj = dif & sum;
		disj = conj | b;
		emit(imm_form(isa_pkg::OP_ADDI, 1, 0, a[15:0]));
		emit(imm_form(isa_pkg::OP_ADDI, 2, 0, b[15:0]));
		// Each result feeds the next one directly
		emit(alu_rr(isa_pkg::FN_ADD, 3, 1, 2));
		emit(alu_rr(isa_pkg::FN_SUB, 4, 3, 2));
		emit(alu_rr(isa_pkg::FN_AND, 5, 4, 3));
		emit(alu_rr(isa_pkg::FN_OR, 6, 5, 2));
		emit(alu_rr(isa_pkg::FN_SLT, 7, 2, 3));
		emit(alu_rr(isa_pkg::FN_SLT, 8, 3, 2));
		emit(imm_form(isa_pkg::OP_SW, 3, 0, 16'd0));
		emit(imm_form(isa_pkg::OP_SW, 4, 0, 16'd4));
		emit(imm_form(isa_pkg::OP_SW, 5, 0, 16'd8));
		emit(imm_form(isa_pkg::OP_SW, 6, 0, 16'd12));
		emit(imm_form(isa_pkg::OP_SW, 7, 0, 16'd16));
		emit(imm_form(isa_pkg::OP_SW, 8, 0, 16'd20));
		expect_store(32'd0, sum);
		expect_store(32'd4, dif);
		expect_store(32'd8, conj);
		expect_store(32'd12, disj);
		expect_store(32'd16, (b < sum) ? 32'd1 : 32'd0);
		expect_store(32'd20, (sum < b) ? 32'd1 : 32'd0);
		run_program("rtype_forwarding");
	endtask

	task automatic test_signed_immediates();
		int a;
		int b;
		enter_reset();
		a = -5;
		b = a - 300;
		emit(imm_form(isa_pkg::OP_ADDI, 1, 0, 16'(a)));
		emit(imm_form(isa_pkg::OP_ADDI, 2, 1, 16'(-300)));
		emit(alu_rr(isa_pkg::FN_SLT, 3, 2, 1));
		emit(alu_rr(isa_pkg::FN_SLT, 4, 1, 0));
		emit(alu_rr(isa_pkg::FN_SLT, 5, 0, 1));
		emit(imm_form(isa_pkg::OP_ADDI, 6, 1, 16'd7));
		emit(alu_rr(isa_pkg::FN_SUB, 7, 0, 1));
		emit(imm_form(isa_pkg::OP_SW, 2, 0, 16'd0));
		emit(imm_form(isa_pkg::OP_SW, 3, 0, 16'd4));
		emit(imm_form(isa_pkg::OP_SW, 4, 0, 16'd8));
		emit(imm_form(isa_pkg::OP_SW, 5, 0, 16'd12));
		emit(imm_form(isa_pkg::OP_SW, 6, 0, 16'd16));
		emit(imm_form(isa_pkg::OP_SW, 7, 0, 16'd20));
		expect_store(32'd0, pipe_pkg::word_t'(b));
		expect_store(32'd4, (b < a) ? 32'd1 : 32'd0);
		expect_store(32'd8, (a < 0) ? 32'd1 : 32'd0);
		expect_store(32'd12, (0 < a) ? 32'd1 : 32'd0);
		expect_store(32'd16, pipe_pkg::word_t'(a + 7));
		expect_store(32'd20, pipe_pkg::word_t'(0 - a));
		run_program("signed_immediates");
	endtask

	task automatic test_load_use();
		pipe_pkg::word_t v;
		enter_reset();
		v = 32'd1234;
		emit(imm_form(isa_pkg::OP_ADDI, 1, 0, v[15:0]));
		emit(imm_form(isa_pkg::OP_SW, 1, 0, 16'd32));
		emit(imm_form(isa_pkg::OP_LW, 2, 0, 16'd32));
		emit(alu_rr(isa_pkg::FN_ADD, 3, 2, 1));
		emit(imm_form(isa_pkg::OP_SW, 3, 0, 16'd36));
		// Loaded value used as store data
		emit(imm_form(isa_pkg::OP_LW, 4, 0, 16'd32));
		emit(imm_form(isa_pkg::OP_SW, 4, 0, 16'd40));
		emit(imm_form(isa_pkg::OP_ADDI, 5, 0, 16'd8));
		emit(imm_form(isa_pkg::OP_LW, 6, 5, 16'd24));
		emit(imm_form(isa_pkg::OP_ADDI, 7, 6, 16'd1));
		emit(imm_form(isa_pkg::OP_SW, 7, 0, 16'd44));
		expect_store(32'd32, v);
		expect_store(32'd36, v + v);
		expect_store(32'd40, v);
		expect_store(32'd44, v + 32'd1);
		run_program("load_use_stall");
	endtask

	task automatic test_branches();
		enter_reset();
		emit(imm_form(isa_pkg::OP_ADDI, 1, 0, 16'd7));
		emit(imm_form(isa_pkg::OP_ADDI, 2, 0, 16'd7));
		emit(imm_form(isa_pkg::OP_ADDI, 3, 0, 16'd9));
		// 7 against 9 falls through
		emit(imm_form(isa_pkg::OP_BEQ, 3, 1, 16'd2));
		emit(imm_form(isa_pkg::OP_SW, 1, 0, 16'd48));
		// 7 against 7 goes to word 8
		emit(imm_form(isa_pkg::OP_BEQ, 2, 1, 16'd2));
		emit(imm_form(isa_pkg::OP_SW, 3, 0, 16'd52));
		emit(imm_form(isa_pkg::OP_SW, 3, 0, 16'd56));
		emit(imm_form(isa_pkg::OP_SW, 3, 0, 16'd60));
		expect_store(32'd48, 32'd7);
		expect_store(32'd60, 32'd9);
		run_program("beq_taken_and_not");
	endtask

	task automatic test_jump();
		enter_reset();
		emit(imm_form(isa_pkg::OP_ADDI, 1, 0, 16'd21));
		emit(imm_form(isa_pkg::OP_SW, 1, 0, 16'd80));
		emit(jump_to(6));
		emit(imm_form(isa_pkg::OP_SW, 1, 0, 16'd84));
		emit(imm_form(isa_pkg::OP_SW, 1, 0, 16'd88));
		emit(imm_form(isa_pkg::OP_SW, 1, 0, 16'd92));
		emit(imm_form(isa_pkg::OP_ADDI, 2, 1, 16'd1));
		emit(imm_form(isa_pkg::OP_SW, 2, 0, 16'd96));
		expect_store(32'd80, 32'd21);
		expect_store(32'd96, 32'd22);
		run_program("jump");
	endtask

	task automatic test_random_sums();
		pipe_pkg::word_t acc;
		pipe_pkg::word_t sum;
		logic [15:0] ia;
		logic [15:0] ib;
		logic [31:0] rnd;
		enter_reset();
		acc = '0;
		for (int k = 0; k < 4; k++) begin
			rnd = $random(seed);
			ia  = rnd[15:0];
			ib  = rnd[31:16];
			sum = sign_extend(ia) + sign_extend(ib);
			acc = acc + sum;
			emit(imm_form(isa_pkg::OP_ADDI, 1, 0, ia));
			emit(imm_form(isa_pkg::OP_ADDI, 2, 0, ib));
			emit(alu_rr(isa_pkg::FN_ADD, 3, 1, 2));
			emit(alu_rr(isa_pkg::FN_ADD, 4, 4, 3));
			emit(imm_form(isa_pkg::OP_SW, 3, 0, 16'(128 + 8 * k)));
			emit(imm_form(isa_pkg::OP_SW, 4, 0, 16'(132 + 8 * k)));
			expect_store(32'(128 + 8 * k), sum);
			expect_store(32'(132 + 8 * k), acc);
		end
		run_program("random_sums");
	endtask

	initial begin
		rst_n_i      = 1'b0;
		collecting   = 1'b0;
		seed         = 32'h950;
		prog_len     = 0;
		cycles       = 0;
		errors       = 0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = '0;
		end
		test_rtype_forwarding();
		test_signed_immediates();
		test_load_use();
		test_branches();
		test_jump();
		test_random_sums();
		// Failed assertions of the bound checker count as errors too
		errors += uut.u_props.fail_count;
		$display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mips_props.sv
`timescale 1ns/1ns
`default_nettype none

module mips_props (
	input wire                  clk,
	input wire                  rst_n_i,
	input wire pipe_pkg::pc_t   imem_addr_i,
	input wire                  dmem_we_i,
	input wire                  stall_i,
	input wire                  flush_i,
	input wire isa_pkg::instr_u d_instr_i
);

	// Number of failed assertions
	int fail_count = 0;

	// Store strobe always driven once out of reset
	we_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(dmem_we_i))
		else begin
			fail_count++;
			$error("dmem_we_o is unknown out of reset");
		end

	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		imem_addr_i[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("imem_addr_o is not word aligned");
		end

	// Fetch address frozen for the stall cycle
	pc_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
		stall_i |=> $stable(imem_addr_i))
		else begin
			fail_count++;
			$error("PC moved while the pipeline was stalled");
		end

	// IF/ID takes a bubble after a flush instead of holding
	flush_clears_fd: assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |=> d_instr_i == '0)
		else begin
			fail_count++;
			$error("IF/ID was not cleared by the flush");
		end

endmodule

bind mips_core mips_props u_props (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.imem_addr_i(imem_addr_o),
	.dmem_we_i(dmem_we_o),
	.stall_i(stall),
	.flush_i(flush),
	.d_instr_i(d_instr)
);

`default_nettype wire

//--- mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core (
	input  wire                  clk,
	input  wire                  rst_n_i,
	output pipe_pkg::pc_t        imem_addr_o,
	input  wire isa_pkg::instr_u imem_instr_i,
	output logic                 dmem_we_o,
	output pipe_pkg::word_t      dmem_addr_o,
	output pipe_pkg::word_t      dmem_wdata_o
);

	isa_pkg::instr_u d_instr;
	logic reg_write, mem_read, mem_write, mem_to_reg, alu_src, reg_dst, branch, jump;
	pipe_pkg::alu_op_e alu_op;

	pipe_pkg::reg_addr_t rf_ra, rf_rb, rf_wa;
	pipe_pkg::word_t rf_rda, rf_rdb, rf_wd;
	logic rf_we;

	pipe_pkg::reg_addr_t d_rs, d_rt, x_rs, x_rt, x_rd, m_rd, w_rd;
	logic x_mem_read, m_reg_write, w_reg_write, redirect;
	pipe_pkg::fwd_sel_e fwd_a, fwd_b;
	logic stall, flush;

	pipe_pkg::word_t dmem_rdata;

	mips_datapath u_datapath (
		.clk(clk), .rst_n_i(rst_n_i),
		.imem_addr_o(imem_addr_o), .imem_instr_i(imem_instr_i),
		.d_instr_o(d_instr),
		.reg_write_i(reg_write), .mem_read_i(mem_read), .mem_write_i(mem_write),
		.mem_to_reg_i(mem_to_reg), .alu_src_i(alu_src), .reg_dst_i(reg_dst),
		.branch_i(branch), .jump_i(jump), .alu_op_i(alu_op),
		.rf_ra_o(rf_ra), .rf_rb_o(rf_rb), .rf_wa_o(rf_wa),
		.rf_rda_i(rf_rda), .rf_rdb_i(rf_rdb), .rf_wd_o(rf_wd), .rf_we_o(rf_we),
		.d_rs_o(d_rs), .d_rt_o(d_rt), .x_rs_o(x_rs), .x_rt_o(x_rt), .x_rd_o(x_rd),
		.m_rd_o(m_rd), .w_rd_o(w_rd),
		.x_mem_read_o(x_mem_read), .m_reg_write_o(m_reg_write),
		.w_reg_write_o(w_reg_write), .redirect_o(redirect),
		.fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .stall_i(stall), .flush_i(flush),
		.dmem_we_o(dmem_we_o), .dmem_addr_o(dmem_addr_o),
		.dmem_wdata_o(dmem_wdata_o), .dmem_rdata_i(dmem_rdata)
	);

	mips_controller u_controller (
		.instr_i(d_instr),
		.reg_write_o(reg_write), .mem_read_o(mem_read), .mem_write_o(mem_write),
		.mem_to_reg_o(mem_to_reg), .alu_src_o(alu_src), .reg_dst_o(reg_dst),
		.branch_o(branch), .jump_o(jump), .alu_op_o(alu_op)
	);

	mips_regfile u_regfile (
		.clk(clk), .rst_n_i(rst_n_i),
		.ra_i(rf_ra), .rb_i(rf_rb), .wa_i(rf_wa), .we_i(rf_we), .wd_i(rf_wd),
		.rda_o(rf_rda), .rdb_o(rf_rdb)
	);

	mips_hazard u_hazard (
		.d_rs_i(d_rs), .d_rt_i(d_rt), .x_rs_i(x_rs), .x_rt_i(x_rt), .x_rd_i(x_rd),
		.m_rd_i(m_rd), .w_rd_i(w_rd),
		.x_mem_read_i(x_mem_read), .m_reg_write_i(m_reg_write),
		.w_reg_write_i(w_reg_write), .redirect_i(redirect),
		.fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall), .flush_o(flush)
	);

	// Same write strobe feeds the memory and the core outputs
	mips_dmem u_dmem (
		.clk(clk), .we_i(dmem_we_o), .addr_i(dmem_addr_o),
		.wdata_i(dmem_wdata_o), .rdata_o(dmem_rdata)
	);

endmodule

`default_nettype wire

//--- mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module mips_datapath (
	input  wire                      clk,
	input  wire                      rst_n_i,
	// Instruction fetch
	output pipe_pkg::pc_t            imem_addr_o,
	input  wire isa_pkg::instr_u     imem_instr_i,
	// Controller
	output isa_pkg::instr_u          d_instr_o,
	input  wire                      reg_write_i, mem_read_i, mem_write_i, mem_to_reg_i,
	input  wire                      alu_src_i, reg_dst_i, branch_i, jump_i,
	input  wire pipe_pkg::alu_op_e   alu_op_i,
	// Register file
	output pipe_pkg::reg_addr_t      rf_ra_o, rf_rb_o, rf_wa_o,
	input  wire pipe_pkg::word_t     rf_rda_i, rf_rdb_i,
	output pipe_pkg::word_t          rf_wd_o,
	output logic                     rf_we_o,
	// Hazard unit
	output pipe_pkg::reg_addr_t      d_rs_o, d_rt_o, x_rs_o, x_rt_o, x_rd_o, m_rd_o, w_rd_o,
	output logic                     x_mem_read_o, m_reg_write_o, w_reg_write_o, redirect_o,
	input  wire pipe_pkg::fwd_sel_e  fwd_a_i, fwd_b_i,
	input  wire                      stall_i, flush_i,
	// Data memory
	output logic                     dmem_we_o,
	output pipe_pkg::word_t          dmem_addr_o, dmem_wdata_o,
	input  wire pipe_pkg::word_t     dmem_rdata_i
);

	pipe_pkg::pc_t pc_q;
	isa_pkg::instr_u fd_instr_q;
	pipe_pkg::pc_t fd_pc4_q;

	logic dx_reg_write_q, dx_mem_read_q, dx_mem_write_q, dx_mem_to_reg_q;
	logic dx_alu_src_q, dx_reg_dst_q, dx_branch_q, dx_jump_q;
	pipe_pkg::alu_op_e dx_alu_op_q;
	isa_pkg::instr_u dx_instr_q;
	pipe_pkg::pc_t dx_pc4_q;
	pipe_pkg::word_t dx_rda_q, dx_rdb_q;

	pipe_pkg::word_t x_imm, x_a, x_b_fwd, x_b, x_alu;
	pipe_pkg::pc_t x_branch_pc, x_jump_pc, x_target;

	logic xm_reg_write_q, xm_mem_write_q, xm_mem_to_reg_q;
	pipe_pkg::word_t xm_alu_q, xm_wdata_q;
	pipe_pkg::reg_addr_t xm_rd_q;

	logic mw_reg_write_q, mw_mem_to_reg_q;
	pipe_pkg::word_t mw_alu_q, mw_rdata_q;
	pipe_pkg::reg_addr_t mw_rd_q;

	function automatic pipe_pkg::word_t fwd_mux(input pipe_pkg::fwd_sel_e sel,
			input pipe_pkg::word_t rf_val, input pipe_pkg::word_t m_val,
			input pipe_pkg::word_t w_val);
		case (sel)
			pipe_pkg::FWD_MEM: return m_val;
			pipe_pkg::FWD_WB:  return w_val;
			default:           return rf_val;
		endcase
	endfunction

	// Fetch, redirect beats stall
	assign imem_addr_o = pc_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else if (redirect_o) begin
			pc_q <= x_target;
		end else if (!stall_i) begin
			pc_q <= pc_q + 32'd4;
		end
	end

	// IF/ID, an all-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (!rst_n_i || flush_i) begin
			fd_instr_q <= '0;
		end else if (!stall_i) begin
			fd_instr_q <= imem_instr_i;
			fd_pc4_q   <= pc_q + 32'd4;
		end
	end

	// Decode
	assign d_instr_o = fd_instr_q;
	assign rf_ra_o   = fd_instr_q.r.rs;
	assign rf_rb_o   = fd_instr_q.r.rt;
	assign d_rs_o    = fd_instr_q.r.rs;
	assign d_rt_o    = fd_instr_q.r.rt;

	// ID/EX control, bubbled on stall or flush
	always_ff @(posedge clk) begin
		if (!rst_n_i || stall_i || flush_i) begin
			dx_reg_write_q  <= 1'b0;
			dx_mem_read_q   <= 1'b0;
			dx_mem_write_q  <= 1'b0;
			dx_mem_to_reg_q <= 1'b0;
			dx_alu_src_q    <= 1'b0;
			dx_reg_dst_q    <= 1'b0;
			dx_branch_q     <= 1'b0;
			dx_jump_q       <= 1'b0;
			dx_alu_op_q     <= pipe_pkg::ALU_ADD;
		end else begin
			dx_reg_write_q  <= reg_write_i;
			dx_mem_read_q   <= mem_read_i;
			dx_mem_write_q  <= mem_write_i;
			dx_mem_to_reg_q <= mem_to_reg_i;
			dx_alu_src_q    <= alu_src_i;
			dx_reg_dst_q    <= reg_dst_i;
			dx_branch_q     <= branch_i;
			dx_jump_q       <= jump_i;
			dx_alu_op_q     <= alu_op_i;
		end
	end

	always_ff @(posedge clk) begin
		dx_instr_q <= fd_instr_q;
		dx_pc4_q   <= fd_pc4_q;
		dx_rda_q   <= rf_rda_i;
		dx_rdb_q   <= rf_rdb_i;
	end

	// Execute
	assign x_rs_o       = dx_instr_q.r.rs;
	assign x_rt_o       = dx_instr_q.r.rt;
	assign x_rd_o       = dx_reg_dst_q ? dx_instr_q.r.rd : dx_instr_q.r.rt;
	assign x_mem_read_o = dx_mem_read_q;

	assign x_imm   = {{16{dx_instr_q.i.imm[15]}}, dx_instr_q.i.imm};
	assign x_a     = fwd_mux(fwd_a_i, dx_rda_q, xm_alu_q, rf_wd_o);
	assign x_b_fwd = fwd_mux(fwd_b_i, dx_rdb_q, xm_alu_q, rf_wd_o);
	assign x_b     = dx_alu_src_q ? x_imm : x_b_fwd;

	always_comb begin
		case (dx_alu_op_q)
			pipe_pkg::ALU_SUB: x_alu = x_a - x_b;
			pipe_pkg::ALU_AND: x_alu = x_a & x_b;
			pipe_pkg::ALU_OR:  x_alu = x_a | x_b;
			pipe_pkg::ALU_SLT: x_alu = {{(pipe_pkg::XLEN-1){1'b0}}, $signed(x_a) < $signed(x_b)};
			default:           x_alu = x_a + x_b;
		endcase
	end

	assign x_branch_pc = dx_pc4_q + {x_imm[29:0], 2'b00};
	assign x_jump_pc   = {dx_pc4_q[31:28], dx_instr_q.j.target, 2'b00};
	assign x_target    = dx_jump_q ? x_jump_pc : x_branch_pc;
	assign redirect_o  = dx_jump_q || (dx_branch_q && x_alu == '0);

	// EX/MEM
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			xm_reg_write_q  <= 1'b0;
			xm_mem_write_q  <= 1'b0;
			xm_mem_to_reg_q <= 1'b0;
		end else begin
			xm_reg_write_q  <= dx_reg_write_q;
			xm_mem_write_q  <= dx_mem_write_q;
			xm_mem_to_reg_q <= dx_mem_to_reg_q;
		end
	end

	// Store data is the forwarded rt
	always_ff @(posedge clk) begin
		xm_alu_q   <= x_alu;
		xm_wdata_q <= x_b_fwd;
		xm_rd_q    <= x_rd_o;
	end

	// Memory
	assign dmem_we_o     = xm_mem_write_q;
	assign dmem_addr_o   = xm_alu_q;
	assign dmem_wdata_o  = xm_wdata_q;
	assign m_rd_o        = xm_rd_q;
	assign m_reg_write_o = xm_reg_write_q;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mw_reg_write_q  <= 1'b0;
			mw_mem_to_reg_q <= 1'b0;
		end else begin
			mw_reg_write_q  <= xm_reg_write_q;
			mw_mem_to_reg_q <= xm_mem_to_reg_q;
		end
	end

	always_ff @(posedge clk) begin
		mw_alu_q   <= xm_alu_q;
		mw_rdata_q <= dmem_rdata_i;
		mw_rd_q    <= xm_rd_q;
	end

	// Writeback
	assign rf_wd_o       = mw_mem_to_reg_q ? mw_rdata_q : mw_alu_q;
	assign rf_wa_o       = mw_rd_q;
	assign rf_we_o       = mw_reg_write_q;
	assign w_rd_o        = mw_rd_q;
	assign w_reg_write_o = mw_reg_write_q;

endmodule

`default_nettype wire

//--- mips_dmem.sv
`timescale 1ns/1ns
`default_nettype none

module mips_dmem (
	input  wire                  clk,
	input  wire                  we_i,
	input  wire pipe_pkg::word_t addr_i,
	input  wire pipe_pkg::word_t wdata_i,
	output pipe_pkg::word_t      rdata_o
);

	pipe_pkg::word_t mem [pipe_pkg::DMEM_WORDS];
	logic [pipe_pkg::DMEM_AW-1:0] idx;

	// Byte address to word index, upper bits ignored
	assign idx = addr_i[pipe_pkg::DMEM_AW+1:2];

	assign rdata_o = mem[idx];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[idx] <= wdata_i;
		end
	end

endmodule

`default_nettype wire

//--- mips_hazard.sv
`timescale 1ns/1ns
`default_nettype none

module mips_hazard (
	input  wire pipe_pkg::reg_addr_t d_rs_i,
	input  wire pipe_pkg::reg_addr_t d_rt_i,
	input  wire pipe_pkg::reg_addr_t x_rs_i,
	input  wire pipe_pkg::reg_addr_t x_rt_i,
	input  wire pipe_pkg::reg_addr_t x_rd_i,
	input  wire pipe_pkg::reg_addr_t m_rd_i,
	input  wire pipe_pkg::reg_addr_t w_rd_i,
	input  wire                      x_mem_read_i,
	input  wire                      m_reg_write_i,
	input  wire                      w_reg_write_i,
	input  wire                      redirect_i,
	output pipe_pkg::fwd_sel_e       fwd_a_o,
	output pipe_pkg::fwd_sel_e       fwd_b_o,
	output logic                     stall_o,
	output logic                     flush_o
);

	logic load_use;

	// Youngest producer wins, r0 is never forwarded
	function automatic pipe_pkg::fwd_sel_e fwd_pick(input pipe_pkg::reg_addr_t src,
			input pipe_pkg::reg_addr_t m_rd, input logic m_we,
			input pipe_pkg::reg_addr_t w_rd, input logic w_we);
		if (src == '0) begin
			return pipe_pkg::FWD_NONE;
		end
		if (m_we && m_rd == src) begin
			return pipe_pkg::FWD_MEM;
		end
		if (w_we && w_rd == src) begin
			return pipe_pkg::FWD_WB;
		end
		return pipe_pkg::FWD_NONE;
	endfunction

	assign fwd_a_o = fwd_pick(x_rs_i, m_rd_i, m_reg_write_i, w_rd_i, w_reg_write_i);
	assign fwd_b_o = fwd_pick(x_rt_i, m_rd_i, m_reg_write_i, w_rd_i, w_reg_write_i);

	// Load data is only ready after the memory stage
	assign load_use = x_mem_read_i && x_rd_i != '0 && (x_rd_i == d_rs_i || x_rd_i == d_rt_i);

	// A redirect squashes the waiting instruction anyway
	assign stall_o = load_use && !redirect_i;
	assign flush_o = redirect_i;

endmodule

`default_nettype wire

//--- mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
	input  wire                      clk,
	input  wire                      rst_n_i,
	input  wire pipe_pkg::reg_addr_t ra_i,
	input  wire pipe_pkg::reg_addr_t rb_i,
	input  wire pipe_pkg::reg_addr_t wa_i,
	input  wire                      we_i,
	input  wire pipe_pkg::word_t     wd_i,
	output pipe_pkg::word_t          rda_o,
	output pipe_pkg::word_t          rdb_o
);

	// r0 has no storage
	pipe_pkg::word_t regs [1:31];

	function pipe_pkg::word_t read_port(input pipe_pkg::reg_addr_t ra);
		if (ra == '0) begin
			return '0;
		end
		// Same-cycle write passes straight through
		if (we_i && wa_i == ra) begin
			return wd_i;
		end
		return regs[ra];
	endfunction

	always_comb begin
		rda_o = read_port(ra_i);
		rdb_o = read_port(rb_i);
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && wa_i != '0) begin
			regs[wa_i] <= wd_i;
		end
	end

endmodule

`default_nettype wire

//--- mips_controller.sv
`timescale 1ns/1ns
`default_nettype none

module mips_controller (
	input  wire isa_pkg::instr_u   instr_i,
	output logic                   reg_write_o,
	output logic                   mem_read_o,
	output logic                   mem_write_o,
	output logic                   mem_to_reg_o,
	output logic                   alu_src_o,
	output logic                   reg_dst_o,
	output logic                   branch_o,
	output logic                   jump_o,
	output pipe_pkg::alu_op_e      alu_op_o
);

	always_comb begin
		// Bubble unless the opcode is recognized
		reg_write_o  = 1'b0;
		mem_read_o   = 1'b0;
		mem_write_o  = 1'b0;
		mem_to_reg_o = 1'b0;
		alu_src_o    = 1'b0;
		reg_dst_o    = 1'b0;
		branch_o     = 1'b0;
		jump_o       = 1'b0;
		alu_op_o     = pipe_pkg::ALU_ADD;
		case (instr_i.r.opcode)
			isa_pkg::OP_RTYPE: begin
				reg_write_o = 1'b1;
				reg_dst_o   = 1'b1;
				case (instr_i.r.funct)
					isa_pkg::FN_ADD: alu_op_o = pipe_pkg::ALU_ADD;
					isa_pkg::FN_SUB: alu_op_o = pipe_pkg::ALU_SUB;
					isa_pkg::FN_AND: alu_op_o = pipe_pkg::ALU_AND;
					isa_pkg::FN_OR:  alu_op_o = pipe_pkg::ALU_OR;
					isa_pkg::FN_SLT: alu_op_o = pipe_pkg::ALU_SLT;
					default: begin
						// Includes the all-zero nop
						reg_write_o = 1'b0;
						reg_dst_o   = 1'b0;
					end
				endcase
			end
			isa_pkg::OP_ADDI: begin
				reg_write_o = 1'b1;
				alu_src_o   = 1'b1;
			end
			isa_pkg::OP_LW: begin
				reg_write_o  = 1'b1;
				mem_read_o   = 1'b1;
				mem_to_reg_o = 1'b1;
				alu_src_o    = 1'b1;
			end
			isa_pkg::OP_SW: begin
				mem_write_o = 1'b1;
				alu_src_o   = 1'b1;
			end
			isa_pkg::OP_BEQ: begin
				// Equality through a zero difference
				branch_o = 1'b1;
				alu_op_o = pipe_pkg::ALU_SUB;
			end
			isa_pkg::OP_J: jump_o = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	localparam int XLEN       = 32;
	localparam int DMEM_WORDS = 64;
	// Word index bits of the data memory
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [XLEN-1:0] pc_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_sel_e;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// Funct codes, only meaningful under OP_RTYPE
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_fields_t;

	// One fetched word seen three ways
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		j_fields_t j;
	} instr_u;

endpackage

`default_nettype wire
